// File: keypad_entry.f
src/keypad_pkg.sv
src/keypad_scanner.sv
src/input_unit.sv
src/keypad_entry.sv
test/tb_clock_gen.sv
test/keypad_entry_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= keypad_entry_tb
FILELIST  ?= keypad_entry.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(wildcard src/*.sv test/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/keypad_entry_tb.sv
`timescale 1ns/100ps
`default_nettype none

module keypad_entry_tb;

    localparam int CLK_PERIOD_NS = 40;
    localparam int RESET_CYCLES  = 3;
    localparam int SWEEP_CYCLES  = 4 * keypad_pkg::SCAN_DIV;
    localparam int PRESS_HOLD    = (keypad_pkg::DEBOUNCE_SCANS + 2) * SWEEP_CYCLES;
    localparam int PRESS_CYCLES  = 2 * PRESS_HOLD;                // hold plus release
    localparam int RANDOM_KEYS   = 40;
    localparam int RANDOM_POOL   = 15;
    localparam int PRESS_TOTAL   = 5 + 17 + 8 + 6 + RANDOM_KEYS;  // presses of tests 2 to 6
    localparam int MARGIN_CYCLES = 2000;                         // reset, enable steps, slack
    localparam int WATCHDOG_NS   = (PRESS_TOTAL * PRESS_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

    logic                                clk;
    logic                                rst_n;
    logic [3:0]                          rows;
    wire  [3:0]                          cols;
    logic [keypad_pkg::SWITCH_CNT-1:0]   switch_map;
    logic                                uart_complete;
    logic                                input_enable;
    logic                                input_complete;
    logic [keypad_pkg::ISA_WIDTH-1:0]    input_data;
    logic                                switch_enable;
    logic                                cpu_pause;

    logic [7:0]                          held_key;         // key currently held on the matrix

    // reference model of the entry controller
    keypad_pkg::entry_state_t            ref_state;
    logic [keypad_pkg::ISA_WIDTH-1:0]    ref_value;
    int                                  ref_digits;
    logic                                ref_complete;
    logic                                ref_switch;
    logic                                ref_pause;

    int     check_errors  = 0;
    int     onehot_errors = 0;
    int     upper_errors  = 0;
    int     test_index    = 0;
    int     tests_failed  = 0;
    int     errors_at_start;
    string  test_name;
    integer seed = 78707;

    keypad_pkg::key_code_t digit_keys [10] = '{
        keypad_pkg::KEY_0, keypad_pkg::KEY_1, keypad_pkg::KEY_2, keypad_pkg::KEY_3,
        keypad_pkg::KEY_4, keypad_pkg::KEY_5, keypad_pkg::KEY_6, keypad_pkg::KEY_7,
        keypad_pkg::KEY_8, keypad_pkg::KEY_9
    };

    // keys drawn by the random sequence test
    keypad_pkg::key_code_t random_keys [RANDOM_POOL] = '{
        keypad_pkg::KEY_0, keypad_pkg::KEY_1, keypad_pkg::KEY_2, keypad_pkg::KEY_3,
        keypad_pkg::KEY_4, keypad_pkg::KEY_5, keypad_pkg::KEY_6, keypad_pkg::KEY_7,
        keypad_pkg::KEY_8, keypad_pkg::KEY_9, keypad_pkg::KEY_BACKSPACE,
        keypad_pkg::KEY_TOGGLE, keypad_pkg::KEY_ENTER, keypad_pkg::KEY_C, keypad_pkg::KEY_D
    };

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    keypad_entry dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .rows           (rows),
        .cols           (cols),
        .switch_map     (switch_map),
        .uart_complete  (uart_complete),
        .input_enable   (input_enable),
        .input_complete (input_complete),
        .input_data     (input_data),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause)
    );

    // the held key pulls its column low while its row is driven
    assign cols = (held_key != 8'h00 && rows == held_key[7:4]) ? held_key[3:0] : 4'b1111;

    assert property (@(posedge clk) disable iff (!rst_n)
        switch_enable |->
            (input_data[keypad_pkg::ISA_WIDTH-1:keypad_pkg::SWITCH_CNT] == '0))
    else begin
        upper_errors = upper_errors + 1;
        $display("** Error: input_data upper bits expected 0x0 got 0x%h",
                 $sampled(input_data[keypad_pkg::ISA_WIDTH-1:keypad_pkg::SWITCH_CNT]));
    end

    assert property (@(posedge clk) disable iff (!rst_n) $onehot(~rows))
    else begin
        onehot_errors = onehot_errors + 1;
        $display("** Error: rows expected one low bit got 0x%h", $sampled(rows));
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic int total_errors();
        return check_errors + onehot_errors + upper_errors;
    endfunction

    function automatic int digit_of(input keypad_pkg::key_code_t key);
        int value;
        value = -1;                                   // not a digit key
        for (int i = 0; i < 10; i++) begin
            if (digit_keys[i] == key) begin
                value = i;
            end
        end
        return value;
    endfunction

    // data memory drops its request once the operand is confirmed
    task automatic wait_cycles(input int count);
        repeat (count) begin
            @(negedge clk);
            if (input_complete && input_enable) begin
                input_enable = 1'b0;
            end
        end
    endtask

    task automatic model_key(input keypad_pkg::key_code_t key);
        int d;
        d = digit_of(key);
        case (ref_state)
            keypad_pkg::BLOCK: begin
                if (key == keypad_pkg::KEY_PAUSE) begin
                    ref_state = keypad_pkg::HALT;
                    ref_pause = 1'b1;
                end
            end
            keypad_pkg::KEYPAD, keypad_pkg::SWITCH: begin
                if (key == keypad_pkg::KEY_TOGGLE) begin
                    ref_switch = (ref_state == keypad_pkg::KEYPAD);
                    if (ref_state == keypad_pkg::KEYPAD) begin
                        ref_state = keypad_pkg::SWITCH;
                    end else begin
                        ref_state = keypad_pkg::KEYPAD;
                    end
                end else if (key == keypad_pkg::KEY_ENTER || key == keypad_pkg::KEY_PAUSE) begin
                    ref_complete = 1'b1;
                    ref_digits   = 0;
                    ref_state    = keypad_pkg::BLOCK;
                    if (key == keypad_pkg::KEY_PAUSE) begin
                        ref_state = keypad_pkg::HALT;
                        ref_pause = 1'b1;
                    end
                end else if (ref_state == keypad_pkg::KEYPAD) begin
                    if (key == keypad_pkg::KEY_BACKSPACE && ref_digits > 0) begin
                        ref_value  = ref_value / 32'd10;
                        ref_digits = ref_digits - 1;
                    end else if (d >= 0 && ref_digits < keypad_pkg::MAX_DIGITS) begin
                        ref_value  = ref_value * 32'd10 + 32'(d);   // wraps at 2^32
                        ref_digits = ref_digits + 1;
                    end
                end
            end
            default: begin
                if (key == keypad_pkg::KEY_PAUSE && uart_complete) begin
                    ref_state = keypad_pkg::BLOCK;
                    ref_pause = 1'b0;
                end
            end
        endcase
    endtask

    // effect of the input_enable level on the reference state
    task automatic model_level();
        if (ref_state == keypad_pkg::BLOCK && input_enable) begin
            ref_state    = keypad_pkg::KEYPAD;
            ref_value    = '0;
            ref_digits   = 0;
            ref_complete = 1'b0;
        end else if (ref_state == keypad_pkg::KEYPAD && !input_enable) begin
            ref_state = keypad_pkg::BLOCK;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual,
                             input string tag);
        assert (actual === expected) else begin
            check_errors = check_errors + 1;
            $display("** Error: %s expected 0x%h got 0x%h after %s", name, expected, actual, tag);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input string tag);
        assert (actual === expected) else begin
            check_errors = check_errors + 1;
            $display("** Error: %s expected 0x%h got 0x%h after %s", name, expected, actual, tag);
        end
    endtask

    task automatic check_outputs(input string tag);
        logic [keypad_pkg::ISA_WIDTH-1:0] exp_data;
        exp_data = ref_value;
        if (ref_switch) begin
            exp_data = {{(keypad_pkg::ISA_WIDTH-keypad_pkg::SWITCH_CNT){1'b0}}, switch_map};
        end
        check_value("input_data", exp_data, input_data, tag);
        check_bit("input_complete", ref_complete, input_complete, tag);
        check_bit("switch_enable", ref_switch, switch_enable, tag);
        check_bit("cpu_pause", ref_pause, cpu_pause, tag);
    endtask

    // hold for one debounced event and release long enough to rearm
    task automatic press(input keypad_pkg::key_code_t key);
        held_key = key;
        wait_cycles(PRESS_HOLD);
        held_key = 8'h00;
        wait_cycles(PRESS_HOLD);
        model_key(key);
        model_level();
        check_outputs(key.name());
    endtask

    task automatic set_enable(input logic level);
        input_enable = level;
        wait_cycles(2);
        model_level();
        check_outputs("input_enable change");
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        test_index      = test_index + 1;
        errors_at_start = total_errors();
    endtask

    task automatic finish_test();
        if (total_errors() == errors_at_start) begin
            $display("test %0d %s: passed", test_index, test_name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: failed", test_index, test_name);
        end
    endtask

    initial begin
        int idx;
        switch_map    = '0;
        uart_complete = 1'b0;
        input_enable  = 1'b0;
        held_key      = 8'h00;
        ref_state     = keypad_pkg::BLOCK;
        ref_value     = '0;
        ref_digits    = 0;
        ref_complete  = 1'b0;
        ref_switch    = 1'b0;
        ref_pause     = 1'b0;
        @(posedge rst_n);
        @(negedge clk);

        start_test("reset");
        check_outputs("reset");
        set_enable(1'b1);
        check_bit("input_complete", 1'b0, input_complete, "entering keypad");
        finish_test();

        start_test("decimal entry");
        press(keypad_pkg::KEY_4);
        press(keypad_pkg::KEY_0);
        press(keypad_pkg::KEY_9);
        press(keypad_pkg::KEY_6);
        press(keypad_pkg::KEY_ENTER);
        check_value("input_data", 32'd4096, input_data, "4096 entered");
        check_bit("input_complete", 1'b1, input_complete, "4096 entered");
        set_enable(1'b0);
        set_enable(1'b1);
        check_value("input_data", 32'd0, input_data, "new request");
        check_bit("input_complete", 1'b0, input_complete, "new request");
        finish_test();

        start_test("edits and limits");
        press(keypad_pkg::KEY_1);
        press(keypad_pkg::KEY_2);
        press(keypad_pkg::KEY_C);                           // below the digit limit
        press(keypad_pkg::KEY_D);
        check_value("input_data", 32'd12, input_data, "unused keys");
        press(keypad_pkg::KEY_BACKSPACE);
        check_value("input_data", 32'd1, input_data, "backspace");
        press(keypad_pkg::KEY_BACKSPACE);
        press(keypad_pkg::KEY_BACKSPACE);                   // nothing left to remove
        check_value("input_data", 32'd0, input_data, "backspace on empty entry");
        for (int i = 1; i <= 9; i++) begin
            press(digit_keys[i]);
        end
        check_value("input_data", 32'd12345678, input_data, "ninth digit");
        press(keypad_pkg::KEY_ENTER);
        set_enable(1'b0);
        set_enable(1'b1);
        finish_test();

        start_test("switch source");
        switch_map = 16'($random(seed));
        press(keypad_pkg::KEY_7);
        press(keypad_pkg::KEY_5);
        press(keypad_pkg::KEY_TOGGLE);
        check_bit("switch_enable", 1'b1, switch_enable, "first toggle");
        check_value("input_data",
                    {{(keypad_pkg::ISA_WIDTH-keypad_pkg::SWITCH_CNT){1'b0}}, switch_map},
                    input_data, "first toggle");
        press(keypad_pkg::KEY_TOGGLE);
        check_value("input_data", 32'd75, input_data, "second toggle");
        press(keypad_pkg::KEY_TOGGLE);
        press(keypad_pkg::KEY_ENTER);
        check_bit("input_complete", 1'b1, input_complete, "enter from switches");
        check_bit("switch_enable", 1'b1, switch_enable, "enter from switches");
        set_enable(1'b1);
        press(keypad_pkg::KEY_TOGGLE);
        press(keypad_pkg::KEY_TOGGLE);                      // back to the keypad source
        finish_test();

        start_test("pause and resume");
        press(keypad_pkg::KEY_3);
        press(keypad_pkg::KEY_PAUSE);
        check_bit("cpu_pause", 1'b1, cpu_pause, "pause during entry");
        check_bit("input_complete", 1'b1, input_complete, "pause during entry");
        press(keypad_pkg::KEY_PAUSE);
        check_bit("cpu_pause", 1'b1, cpu_pause, "resume before upload");
        uart_complete = 1'b1;
        press(keypad_pkg::KEY_PAUSE);
        check_bit("cpu_pause", 1'b0, cpu_pause, "resume after upload");
        press(keypad_pkg::KEY_PAUSE);
        check_bit("cpu_pause", 1'b1, cpu_pause, "pause while idle");
        press(keypad_pkg::KEY_PAUSE);
        set_enable(1'b1);
        finish_test();

        start_test("random sequences");
        for (int n = 0; n < RANDOM_KEYS; n++) begin
            switch_map = 16'($random(seed));
            idx = int'($unsigned($random(seed)) % RANDOM_POOL);
            press(random_keys[idx]);
            if (!input_enable) begin
                set_enable(1'b1);                           // next operand request
            end
        end
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_index, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;    // released on a falling edge away from the sampling edge
    end

endmodule

`default_nettype wire

// File: src/keypad_entry.sv
`timescale 1ns/100ps
`default_nettype none

module keypad_entry (
    input  wire                                  clk,
    input  wire                                  rst_n,

    // keypad matrix
    output logic [3:0]                           rows,           // active low row drive
    input  wire  [3:0]                           cols,           // active low column sense

    // board and uart
    input  wire  [keypad_pkg::SWITCH_CNT-1:0]    switch_map,
    input  wire                                  uart_complete,

    // cpu side
    input  wire                                  input_enable,   // from data memory
    output logic                                 input_complete, // to hazard unit
    output logic [keypad_pkg::ISA_WIDTH-1:0]     input_data,     // to data memory
    output logic                                 switch_enable,
    output logic                                 cpu_pause       // to hazard unit
);

    keypad_pkg::key_code_t key_coord;   // debounced key events

    keypad_scanner u_scanner (
        .clk       (clk),
        .rst_n     (rst_n),
        .rows      (rows),
        .cols      (cols),
        .key_coord (key_coord)
    );

    input_unit u_input_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_coord      (key_coord),
        .switch_map     (switch_map),
        .uart_complete  (uart_complete),
        .input_enable   (input_enable),
        .input_complete (input_complete),
        .input_data     (input_data),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause)
    );

endmodule

`default_nettype wire

// File: src/input_unit.sv
`timescale 1ns/100ps
`default_nettype none

module input_unit (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  var   keypad_pkg::key_code_t          key_coord,      // key event from the scanner
    input  wire  [keypad_pkg::SWITCH_CNT-1:0]    switch_map,     // toggle switches
    input  wire                                  uart_complete,  // program upload finished
    input  wire                                  input_enable,   // data memory wants an operand
    output logic                                 input_complete, // operand confirmed
    output logic [keypad_pkg::ISA_WIDTH-1:0]     input_data,     // operand toward data memory
    output logic                                 switch_enable,  // switches are the source
    output logic                                 cpu_pause       // hold the cpu
);

    keypad_pkg::entry_state_t               state;
    logic [keypad_pkg::DIGIT_CNT_W-1:0]     digit_cnt;     // digits currently in keypad_data
    logic [keypad_pkg::ISA_WIDTH-1:0]       keypad_data;   // decimal value typed so far
    logic [keypad_pkg::ISA_WIDTH-1:0]       digit_ext;
    logic [3:0]                             digit_val;
    logic                                   is_digit;
    logic                                   in_keypad;

    // digit keys to their value
    always_comb begin
        is_digit  = 1'b1;
        digit_val = 4'd0;
        case (key_coord)
            keypad_pkg::KEY_0: digit_val = 4'd0;
            keypad_pkg::KEY_1: digit_val = 4'd1;
            keypad_pkg::KEY_2: digit_val = 4'd2;
            keypad_pkg::KEY_3: digit_val = 4'd3;
            keypad_pkg::KEY_4: digit_val = 4'd4;
            keypad_pkg::KEY_5: digit_val = 4'd5;
            keypad_pkg::KEY_6: digit_val = 4'd6;
            keypad_pkg::KEY_7: digit_val = 4'd7;
            keypad_pkg::KEY_8: digit_val = 4'd8;
            keypad_pkg::KEY_9: digit_val = 4'd9;
            default:           is_digit  = 1'b0;   // commands, C, D and no event
        endcase
    end

    assign digit_ext = {{(keypad_pkg::ISA_WIDTH-4){1'b0}}, digit_val};
    assign in_keypad = (state == keypad_pkg::KEYPAD);

    // switch source shows the switches zero extended
    assign input_data = switch_enable ?
                        {{(keypad_pkg::ISA_WIDTH-keypad_pkg::SWITCH_CNT){1'b0}}, switch_map} :
                        keypad_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= keypad_pkg::BLOCK;
            digit_cnt      <= '0;
            keypad_data    <= '0;
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
            cpu_pause      <= 1'b0;
        end else begin
            case (state)
                keypad_pkg::BLOCK: begin
                    if (key_coord == keypad_pkg::KEY_PAUSE) begin
                        state     <= keypad_pkg::HALT;
                        cpu_pause <= 1'b1;
                    end else if (input_enable) begin
                        state          <= keypad_pkg::KEYPAD;   // new entry starts empty
                        keypad_data    <= '0;
                        digit_cnt      <= '0;
                        input_complete <= 1'b0;
                    end
                end

                keypad_pkg::KEYPAD,
                keypad_pkg::SWITCH: begin
                    if (in_keypad && !input_enable) begin
                        state <= keypad_pkg::BLOCK;             // request withdrawn
                    end else begin
                        case (key_coord)
                            keypad_pkg::KEY_TOGGLE: begin
                                state         <= in_keypad ? keypad_pkg::SWITCH :
                                                             keypad_pkg::KEYPAD;
                                switch_enable <= in_keypad;
                            end
                            keypad_pkg::KEY_ENTER: begin
                                state          <= keypad_pkg::BLOCK;
                                input_complete <= 1'b1;
                                digit_cnt      <= '0;
                            end
                            keypad_pkg::KEY_PAUSE: begin
                                // confirms the operand and pauses in one go
                                state          <= keypad_pkg::HALT;
                                input_complete <= 1'b1;
                                digit_cnt      <= '0;
                                cpu_pause      <= 1'b1;
                            end
                            keypad_pkg::KEY_BACKSPACE: begin
                                if (in_keypad && digit_cnt != '0) begin
                                    keypad_data <= keypad_data / keypad_pkg::DEC_BASE;
                                    digit_cnt   <= digit_cnt - 1'b1;
                                end
                            end
                            default: begin
                                if (in_keypad && is_digit &&
                                    digit_cnt < keypad_pkg::DIGIT_LIMIT) begin
                                    keypad_data <= keypad_data * keypad_pkg::DEC_BASE + digit_ext;
                                    digit_cnt   <= digit_cnt + 1'b1;
                                end
                            end
                        endcase
                    end
                end

                keypad_pkg::HALT: begin
                    // resume only once the upload is done
                    if (uart_complete && key_coord == keypad_pkg::KEY_PAUSE) begin
                        state     <= keypad_pkg::BLOCK;
                        cpu_pause <= 1'b0;
                    end
                end

                default: begin
                    state <= keypad_pkg::BLOCK;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/keypad_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module keypad_scanner (
    input  wire                        clk,
    input  wire                        rst_n,
    output logic [3:0]                 rows,        // one row low at a time
    input  wire  [3:0]                 cols,        // pulled high, low on a pressed key
    output keypad_pkg::key_code_t      key_coord    // one cycle per press and KEY_NONE otherwise
);

    logic [keypad_pkg::SCAN_DIV_W-1:0] div_cnt;     // position inside the row window
    logic [keypad_pkg::DEBOUNCE_W-1:0] stable_cnt;  // sweeps that showed last_code
    logic [keypad_pkg::DEBOUNCE_W-1:0] next_cnt;
    logic                              pressed;     // a reported key is still down
    logic                              window_end;
    logic                              sweep_end;
    logic                              row_hit;
    logic                              stable;
    keypad_pkg::key_code_t             cand;        // first key found in this sweep
    keypad_pkg::key_code_t             sweep_code;  // sweep result including the current row
    keypad_pkg::key_code_t             last_code;   // result of the previous sweep

    // lowest numbered low column as an active-low one-hot pattern
    function automatic logic [3:0] first_low_col(input logic [3:0] c);
        logic [3:0] pat;
        pat = 4'b1111;
        if (!c[0]) begin
            pat = 4'b1110;
        end else if (!c[1]) begin
            pat = 4'b1101;
        end else if (!c[2]) begin
            pat = 4'b1011;
        end else if (!c[3]) begin
            pat = 4'b0111;
        end
        return pat;
    endfunction

    assign window_end = (div_cnt == keypad_pkg::SCAN_DIV_LAST);
    assign sweep_end  = window_end && !rows[3];   // row 3 is the last of the sweep
    assign row_hit    = (cols != 4'b1111);

    // an earlier row in the sweep keeps its key even if this row has one too
    always_comb begin
        if (cand != keypad_pkg::KEY_NONE) begin
            sweep_code = cand;
        end else if (row_hit) begin
            sweep_code = keypad_pkg::key_code_t'({rows, first_low_col(cols)});
        end else begin
            sweep_code = keypad_pkg::KEY_NONE;
        end
    end

    // consecutive agreeing sweeps saturate at the debounce limit
    always_comb begin
        if (sweep_code != last_code) begin
            next_cnt = {{(keypad_pkg::DEBOUNCE_W-1){1'b0}}, 1'b1};
        end else if (stable_cnt == keypad_pkg::DEBOUNCE_DONE) begin
            next_cnt = stable_cnt;
        end else begin
            next_cnt = stable_cnt + 1'b1;
        end
    end

    assign stable = (next_cnt == keypad_pkg::DEBOUNCE_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            rows       <= 4'b1110;                  // row 0 driven first
            cand       <= keypad_pkg::KEY_NONE;
            last_code  <= keypad_pkg::KEY_NONE;
            stable_cnt <= '0;
            pressed    <= 1'b0;
            key_coord  <= keypad_pkg::KEY_NONE;
        end else begin
            key_coord <= keypad_pkg::KEY_NONE;      // event lasts a single cycle

            if (window_end) begin
                div_cnt <= '0;
                rows    <= {rows[2:0], rows[3]};    // step to the next row
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (sweep_end) begin
                cand       <= keypad_pkg::KEY_NONE;
                last_code  <= sweep_code;
                stable_cnt <= next_cnt;
                if (stable && sweep_code != keypad_pkg::KEY_NONE && !pressed) begin
                    pressed   <= 1'b1;
                    key_coord <= sweep_code;
                end else if (stable && sweep_code == keypad_pkg::KEY_NONE) begin
                    pressed   <= 1'b0;              // released long enough to rearm
                end
            end else if (window_end) begin
                cand <= sweep_code;                 // keeps an earlier find unchanged
            end
        end
    end

endmodule

`default_nettype wire

// File: src/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    localparam int ISA_WIDTH      = 32;   // operand word handed to data memory
    localparam int SWITCH_CNT     = 16;   // board toggle switches
    localparam int MAX_DIGITS     = 8;    // decimal digits accepted per entry
    localparam int SCAN_DIV       = 8;    // cycles each row stays driven
    localparam int DEBOUNCE_SCANS = 3;    // equal sweeps needed for press or release

    localparam int SCAN_DIV_W  = $clog2(SCAN_DIV);
    localparam int DEBOUNCE_W  = $clog2(DEBOUNCE_SCANS + 1);
    localparam int DIGIT_CNT_W = $clog2(MAX_DIGITS + 1);

    // limits at the width of the counters they are compared with
    localparam logic [SCAN_DIV_W-1:0]  SCAN_DIV_LAST = SCAN_DIV_W'(SCAN_DIV - 1);
    localparam logic [DEBOUNCE_W-1:0]  DEBOUNCE_DONE = DEBOUNCE_W'(DEBOUNCE_SCANS);
    localparam logic [DIGIT_CNT_W-1:0] DIGIT_LIMIT   = DIGIT_CNT_W'(MAX_DIGITS);
    localparam logic [ISA_WIDTH-1:0]   DEC_BASE      = ISA_WIDTH'(10);

    // row pattern above column pattern with both active low
    // row 0 and column 0 sit in bit 0 of their patterns
    typedef enum logic [7:0] {
        KEY_NONE      = 8'b0000_0000,    // no event this cycle
        KEY_1         = 8'b1110_1110,
        KEY_2         = 8'b1110_1101,
        KEY_3         = 8'b1110_1011,
        KEY_PAUSE     = 8'b1110_0111,    // "A"
        KEY_4         = 8'b1101_1110,
        KEY_5         = 8'b1101_1101,
        KEY_6         = 8'b1101_1011,
        KEY_TOGGLE    = 8'b1101_0111,    // "B"
        KEY_7         = 8'b1011_1110,
        KEY_8         = 8'b1011_1101,
        KEY_9         = 8'b1011_1011,
        KEY_C         = 8'b1011_0111,
        KEY_BACKSPACE = 8'b0111_1110,    // "*"
        KEY_0         = 8'b0111_1101,
        KEY_ENTER     = 8'b0111_1011,    // "#"
        KEY_D         = 8'b0111_0111
    } key_code_t;

    typedef enum logic [1:0] {
        BLOCK  = 2'b00,    // waiting for data memory to ask for input
        SWITCH = 2'b01,    // operand comes from the toggle switches
        KEYPAD = 2'b10,    // decimal entry in progress
        HALT   = 2'b11     // cpu held until resumed
    } entry_state_t;

endpackage

`default_nettype wire
